// File: source/calc_pkg.sv
package calc_pkg;

    // Datapath widths
    localparam int DATA_W    = 16;               // Operand and result width
    localparam int DIGIT_W   = 4;                // Keypad code width
    localparam int OP_W      = 3;                // Operator code width
    localparam int PROD_W    = 2 * DATA_W;       // Full multiplier product
    localparam int MUL_STEPS = 16;               // One step per multiplier bit
    localparam int STEP_W    = $clog2(MUL_STEPS); // Step counter width

    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9; // Codes above are not digits

    // One-hot operator codes, same as the keypad operator port
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } calc_op_e;

    // Controller sequence
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,  // Waiting for a request
        CTRL_START = 2'd1,  // Start pulse to arith unit
        CTRL_WAIT  = 2'd2,  // Waiting for finish
        CTRL_DONE  = 2'd3   // Result valid to display
    } ctrl_state_e;

    // Which operand the keypad is filling
    typedef enum logic {
        PH_FIRST  = 1'b0,
        PH_SECOND = 1'b1
    } entry_phase_e;

    // Calculation request, entry to controller to arith unit
    typedef struct packed {
        logic [DATA_W-1:0] a;   // Left operand
        logic [DATA_W-1:0] b;   // Right operand
        calc_op_e          op;  // Operation
    } calc_req_t;

    // Calculation response, arith unit to controller to display
    typedef struct packed {
        logic [DATA_W-1:0] value;     // Low DATA_W bits of result
        logic              overflow;  // Carry, borrow or upper product bits
    } calc_rsp_t;

endpackage

// File: source/operand_entry.sv
module operand_entry import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic [DIGIT_W-1:0] keypad_input,    // Decimal digit code
    input  logic               read_input,      // Digit strobe
    input  logic [OP_W-1:0]    operator_input,  // Operator code, zero when idle
    input  logic               equal_input,     // Equal strobe
    input  logic               busy,            // Calculation in flight
    input  logic               clear,           // Result accepted, start over
    output calc_req_t          req,
    output logic               req_valid
);

    entry_phase_e      phase_q;  // Operand being entered
    logic [DATA_W-1:0] opa_q;    // First operand
    logic [DATA_W-1:0] opb_q;    // Second operand
    calc_op_e          op_q;     // Latched operator
    logic              blocked;  // Drop all keypad activity
    logic              digit_ok; // Strobed code is 0 to 9
    logic              op_ok;    // Operator code is one we support

    // Operand times ten plus digit, wraps at DATA_W bits
    function automatic logic [DATA_W-1:0] shift_in_digit(
        input logic [DATA_W-1:0]  value,
        input logic [DIGIT_W-1:0] digit
    );
        return (value << 3) + (value << 1) + DATA_W'(digit);
    endfunction

    // Request cycle itself also blocked, busy only rises one cycle later
    assign blocked  = busy | req_valid;
    assign digit_ok = read_input && (keypad_input <= DIGIT_MAX);
    assign op_ok    = operator_input inside {OP_ADD, OP_SUB, OP_MUL};

    assign req = '{a: opa_q, b: opb_q, op: op_q}; // Stable until clear

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            phase_q   <= PH_FIRST;
            opa_q     <= '0;
            opb_q     <= '0;
            op_q      <= OP_ADD;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;                       // Single-cycle strobe
            if (clear) begin                         // Result out, fresh entry
                opa_q   <= '0;
                opb_q   <= '0;
                phase_q <= PH_FIRST;
            end else if (!blocked) begin
                case (phase_q)
                    PH_FIRST: begin
                        if (digit_ok)
                            opa_q <= shift_in_digit(opa_q, keypad_input);
                        if (op_ok) begin             // Bad codes keep us here
                            op_q    <= calc_op_e'(operator_input);
                            phase_q <= PH_SECOND;
                        end
                    end
                    PH_SECOND: begin
                        if (equal_input)             // Equal wins over a digit
                            req_valid <= 1'b1;
                        else if (digit_ok)
                            opb_q <= shift_in_digit(opb_q, keypad_input);
                    end
                    default: phase_q <= PH_FIRST;
                endcase
            end
        end
    end

endmodule

// File: source/calc_controller.sv
module calc_controller import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  calc_req_t req,           // From operand entry
    input  logic      req_valid,
    output logic      busy,          // Back to operand entry
    output calc_req_t arith_req,     // To arith unit
    output logic      start,
    input  calc_rsp_t rsp,           // From arith unit
    input  logic      finish,
    output calc_rsp_t result,        // To display
    output logic      result_valid
);

    ctrl_state_e state_q;  // Current state
    ctrl_state_e state_d;  // Next state
    logic        accept;   // Take a new request
    logic        capture;  // Take the arith response

    assign accept  = (state_q == CTRL_IDLE) && req_valid;
    assign capture = (state_q == CTRL_WAIT) && finish;

    // Strobes decoded from registered state
    assign busy         = (state_q != CTRL_IDLE);
    assign start        = (state_q == CTRL_START);   // One cycle only
    assign result_valid = (state_q == CTRL_DONE);    // One cycle only

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (req_valid)
                    state_d = CTRL_START;
            end
            CTRL_START: begin
                state_d = CTRL_WAIT;                 // Start pulse done
            end
            CTRL_WAIT: begin
                if (finish)                          // 1 cycle add/sub, 16 mul
                    state_d = CTRL_DONE;
            end
            CTRL_DONE: begin
                state_d = CTRL_IDLE;                 // Entry clears this cycle
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and response holding registers
    always_ff @(posedge clk) begin
        if (accept)
            arith_req <= req;                        // Held through the op
        if (capture)
            result <= rsp;                           // Presented in CTRL_DONE
    end

endmodule

// File: source/arith_unit.sv
module arith_unit import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  calc_req_t arith_req,  // Operands and operator
    input  logic      start,      // Launch strobe
    output calc_rsp_t rsp,        // Valid with finish
    output logic      finish      // Single-cycle done strobe
);

    logic [DATA_W:0]   add_sum;      // Sum with carry out
    logic [DATA_W:0]   sub_diff;     // Difference with borrow
    logic              mul_go;       // Multiply launched this cycle
    logic              mul_busy_q;   // Multiply steps running
    logic [STEP_W-1:0] step_q;       // Steps already done
    logic              last_step;    // Final multiplier step
    logic [PROD_W-1:0] acc_q;        // Partial product
    logic [PROD_W-1:0] mcand_q;      // Shifted multiplicand
    logic [DATA_W-1:0] mplier_q;     // Remaining multiplier bits
    logic [PROD_W-1:0] iter_acc;     // Step inputs, taken from the
    logic [PROD_W-1:0] iter_mcand;   // request on the launch cycle
    logic [DATA_W-1:0] iter_mplier;
    logic [PROD_W-1:0] step_sum;     // Accumulator after this step

    assign add_sum  = {1'b0, arith_req.a} + {1'b0, arith_req.b};
    assign sub_diff = {1'b0, arith_req.a} - {1'b0, arith_req.b}; // MSB set on borrow

    assign mul_go    = start && (arith_req.op == OP_MUL);
    assign last_step = mul_busy_q && (step_q == STEP_W'(MUL_STEPS - 1));

    // Launch cycle already does step one
    assign iter_acc    = mul_go ? '0 : acc_q;
    assign iter_mcand  = mul_go ? PROD_W'(arith_req.a) : mcand_q;
    assign iter_mplier = mul_go ? arith_req.b : mplier_q;
    assign step_sum    = iter_acc + (iter_mplier[0] ? iter_mcand : '0);

    // Sequencing and finish strobe
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish     <= 1'b0;
            mul_busy_q <= 1'b0;
            step_q     <= '0;
        end else begin
            finish <= 1'b0;
            if (mul_go) begin
                mul_busy_q <= 1'b1;
                step_q     <= STEP_W'(1);            // First step taken now
            end else if (start) begin
                finish <= 1'b1;                      // Add/sub, next cycle
            end else if (mul_busy_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) begin
                    mul_busy_q <= 1'b0;
                    finish     <= 1'b1;              // MUL_STEPS after start
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (mul_go || mul_busy_q) begin
            acc_q    <= step_sum;
            mcand_q  <= iter_mcand << 1;
            mplier_q <= iter_mplier >> 1;
        end
        if (start) begin
            case (arith_req.op)
                OP_SUB: begin
                    rsp.value    <= sub_diff[DATA_W-1:0];  // Wraps below zero
                    rsp.overflow <= sub_diff[DATA_W];
                end
                OP_ADD: begin
                    rsp.value    <= add_sum[DATA_W-1:0];
                    rsp.overflow <= add_sum[DATA_W];
                end
                default: ;                           // Multiply fills rsp later
            endcase
        end else if (last_step) begin
            rsp.value    <= step_sum[DATA_W-1:0];    // Low half shown
            rsp.overflow <= |step_sum[PROD_W-1:DATA_W];
        end
    end

endmodule

// File: source/result_display.sv
module result_display import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  calc_rsp_t         result,          // From controller
    input  logic              result_valid,
    output logic [DATA_W-1:0] display_output,  // Held until next result
    output logic              overflow,
    output logic              complete         // One pulse per result
);

    // Display holds its value between calculations
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            overflow       <= 1'b0;
            complete       <= 1'b0;
        end else begin
            complete <= result_valid;                // Aligned with new value
            if (result_valid) begin
                display_output <= result.value;
                overflow       <= result.overflow;
            end
        end
    end

endmodule

// File: source/calculator_top.sv
module calculator_top import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic [DIGIT_W-1:0] keypad_input,
    input  logic               read_input,
    input  logic [OP_W-1:0]    operator_input,
    input  logic               equal_input,
    output logic [DATA_W-1:0]  display_output,
    output logic               overflow,
    output logic               complete
);

    calc_req_t req;           // Entry to controller
    logic      req_valid;
    logic      busy;          // Controller back to entry
    calc_req_t arith_req;     // Controller to arith unit
    logic      start;
    calc_rsp_t rsp;           // Arith unit to controller
    logic      finish;
    calc_rsp_t result;        // Controller to display
    logic      result_valid;  // Also clears the entry side

    operand_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .clear          (result_valid),
        .req            (req),
        .req_valid      (req_valid)
    );

    calc_controller u_ctrl (
        .clk          (clk),
        .nRST         (nRST),
        .req          (req),
        .req_valid    (req_valid),
        .busy         (busy),
        .arith_req    (arith_req),
        .start        (start),
        .rsp          (rsp),
        .finish       (finish),
        .result       (result),
        .result_valid (result_valid)
    );

    arith_unit u_arith (
        .clk       (clk),
        .nRST      (nRST),
        .arith_req (arith_req),
        .start     (start),
        .rsp       (rsp),
        .finish    (finish)
    );

    result_display u_display (
        .clk            (clk),
        .nRST           (nRST),
        .result         (result),
        .result_valid   (result_valid),
        .display_output (display_output),
        .overflow       (overflow),
        .complete       (complete)
    );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 10;  // Rising edges spent in reset

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                // Release away from the sampling edge
        nRST = 1'b1;
    end

endmodule

// File: tb/calc_checker.sv
module calc_checker import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic              equal_input,     // Same strobe the DUT sees
    input  logic [DATA_W-1:0] display_output,
    input  logic              overflow,
    input  logic              complete,
    input  logic [DATA_W-1:0] exp_value,       // Expected result of current case
    input  logic              exp_overflow,
    input  int                exp_latency,     // Cycles from equal to complete
    output int                error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int                value_errs   = 0;
    int                latency_errs = 0;
    int                lost_errs    = 0;
    int                strobe_errs  = 0;
    int                cycle        = 0;     // Rising edges seen
    int                equal_cycle  = 0;     // Edge that took the equal
    bit                pending      = 1'b0;  // Calculation launched, no result yet
    bit                check_reset  = 1'b0;
    logic              complete_prev;
    logic [DATA_W-1:0] held_value;           // Last displayed result
    logic              held_ovf;

    assign error_count = value_errs + latency_errs + lost_errs + strobe_errs;

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            value_errs++;
            $display("mismatch %s expected 0x%04h actual 0x%04h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d value, %0d latency, %0d missing, %0d strobe, %0d total",
                 value_errs, latency_errs, lost_errs, strobe_errs, error_count);
    endtask

    // Outputs are registered, so the values seen here settled a cycle ago
    always @(posedge clk) begin
        cycle++;
        if (!nRST) begin
            check_reset   = 1'b1;
            pending       = 1'b0;
            complete_prev = 1'b0;
            held_value    = '0;
            held_ovf      = 1'b0;
        end else begin
            if (check_reset) begin                        // First edge out of reset
                check_value("display_output", '0, display_output);
                check_value("overflow", '0, DATA_W'(overflow));
                if (complete !== 1'b0) begin
                    strobe_errs++;
                    $display("complete is not low right after reset");
                end
                check_reset = 1'b0;
            end
            if (equal_input && !pending) begin            // Later equals are strays
                pending     = 1'b1;
                equal_cycle = cycle;
            end
            if (complete) begin
                if (complete_prev) begin
                    strobe_errs++;
                    $display("complete stayed high for more than one cycle at %0t", $time);
                end else if (!pending) begin
                    strobe_errs++;
                    $display("complete arrived with no calculation pending at %0t", $time);
                end else begin
                    if (cycle - equal_cycle != exp_latency) begin
                        latency_errs++;
                        $display("complete came %0d cycles after equal instead of %0d",
                                 cycle - equal_cycle, exp_latency);
                    end
                    check_value("display_output", exp_value, display_output);
                    check_value("overflow", DATA_W'(exp_overflow), DATA_W'(overflow));
                end
                pending    = 1'b0;
                held_value = display_output;
                held_ovf   = overflow;
            end else begin
                check_value("display_output", held_value, display_output); // Must hold
                check_value("overflow", DATA_W'(held_ovf), DATA_W'(overflow));
                if (pending && (cycle - equal_cycle > exp_latency + 5)) begin
                    lost_errs++;
                    pending = 1'b0;
                    $display("complete never arrived after the equal strobe at %0t", $time);
                end
            end
            complete_prev = complete;
        end
    end

endmodule

// File: tb/tb_calculator.sv
module tb_calculator import calc_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM     = 40;  // Extra random calculations
    localparam int CASE_CYCLES  = 40;  // Budget per calculation
    localparam int RESET_CYCLES = 10;

    logic               clk;
    logic               nRST;
    logic [DIGIT_W-1:0] keypad_input;
    logic               read_input;
    logic [OP_W-1:0]    operator_input;
    logic               equal_input;
    logic [DATA_W-1:0]  display_output;
    logic               overflow;
    logic               complete;
    logic [DATA_W-1:0]  exp_value;
    logic               exp_overflow;
    int                 exp_latency;
    int                 error_count;
    int                 table_size = 0;

    // Stimulus table, one slot per calculation
    string              a_q[$];          // Operand a keys, '#' sends the bad operator
    string              b_q[$];          // Operand b keys, a..f are keypad codes 10..15
    logic [OP_W-1:0]    op_q[$];
    logic [OP_W-1:0]    bad_op_q[$];
    bit                 noise_q[$];      // Strobes thrown in while busy
    logic [DATA_W-1:0]  val_q[$];
    bit                 ovf_q[$];

    tb_clock_gen u_clk (.clk(clk), .nRST(nRST));

    calculator_top DUT (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .display_output (display_output),
        .overflow       (overflow),
        .complete       (complete)
    );

    calc_checker u_checker (
        .clk            (clk),
        .nRST           (nRST),
        .equal_input    (equal_input),
        .display_output (display_output),
        .overflow       (overflow),
        .complete       (complete),
        .exp_value      (exp_value),
        .exp_overflow   (exp_overflow),
        .exp_latency    (exp_latency),
        .error_count    (error_count)
    );

    task automatic add_case(input string a, input logic [OP_W-1:0] code, input string b,
                            input logic [OP_W-1:0] bad_op, input bit noise,
                            input logic [DATA_W-1:0] value, input bit ovf);
        a_q.push_back(a);
        op_q.push_back(code);
        b_q.push_back(b);
        bad_op_q.push_back(bad_op);
        noise_q.push_back(noise);
        val_q.push_back(value);
        ovf_q.push_back(ovf);
    endtask

    // Decimal accumulation by the keypad rules, non-digits skipped
    function automatic int operand_value(input string s);
        int  v;
        byte c;
        v = 0;
        for (int i = 0; i < s.len(); i++) begin
            c = s[i];
            if (c >= "0" && c <= "9")
                v = (v * 10 + (c - "0")) % 65536;
        end
        return v;
    endfunction

    // {overflow, value} from the wrap and overflow rules
    function automatic logic [DATA_W:0] reference_result(input int a, input int b,
                                                         input logic [OP_W-1:0] code);
        longint full;
        case (code)
            OP_ADD:  full = a + b;
            OP_SUB:  full = a - b;               // Negative means borrow
            default: full = longint'(a) * b;
        endcase
        return {(full < 0 || full > 65535), 16'(full)};
    endfunction

    // Each strobe task starts and ends on a falling edge
    task automatic send_key(input logic [DIGIT_W-1:0] code);
        keypad_input = code;
        read_input   = 1'b1;
        @(negedge clk);
        read_input   = 1'b0;
        keypad_input = '0;
    endtask

    task automatic send_op(input logic [OP_W-1:0] code);
        operator_input = code;
        @(negedge clk);
        operator_input = '0;
    endtask

    task automatic send_equal();
        equal_input = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
    endtask

    task automatic send_operand(input string s, input logic [OP_W-1:0] bad_op);
        byte c;
        for (int i = 0; i < s.len(); i++) begin
            c = s[i];
            if (c == "#")
                send_op(bad_op);
            else if (c >= "a")
                send_key(DIGIT_W'(c - "a" + 10));
            else
                send_key(DIGIT_W'(c - "0"));
        end
    endtask

    task automatic run_case(input string a, input logic [OP_W-1:0] code, input string b,
                            input logic [OP_W-1:0] bad_op, input bit noise,
                            input logic [DATA_W-1:0] value, input bit ovf);
        int n;
        exp_value    = value;
        exp_overflow = ovf;
        exp_latency  = (code == OP_MUL) ? 20 : 5;
        send_operand(a, bad_op);
        send_op(code);
        send_operand(b, bad_op);
        send_equal();
        if (noise) begin                         // All of it lands while busy
            send_key(4'd7);
            send_op(OP_SUB);
            send_key(4'd3);
            send_equal();
            send_op(OP_ADD);
            send_key(4'd9);
        end
        n = 0;
        while (complete !== 1'b1 && n < CASE_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);                          // Let the checker take complete
    endtask

    initial begin : watchdog
        wait (table_size > 0);
        repeat ((table_size + N_RANDOM) * CASE_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish in time");
        u_checker.print_counts();
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int                seed;
        string             a;
        string             b;
        logic [OP_W-1:0]   code;
        logic [DATA_W:0]   expected;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        exp_value      = '0;
        exp_overflow   = 1'b0;
        exp_latency    = 5;
        seed = 38326;
        void'($urandom(seed));
        //       a         op      b        bad op  busy  value       ovf
        add_case("1234",   OP_ADD, "567",   3'b000, 1'b0, 16'd1801,   1'b0);
        add_case("99999",  OP_ADD, "0",     3'b000, 1'b0, 16'd34463,  1'b0);
        add_case("1c2f3",  OP_SUB, "3",     3'b000, 1'b0, 16'd120,    1'b0);
        add_case("60000",  OP_ADD, "10000", 3'b000, 1'b0, 16'd4464,   1'b1);
        add_case("5",      OP_SUB, "9",     3'b000, 1'b0, 16'hFFFC,   1'b1);
        add_case("300",    OP_MUL, "300",   3'b000, 1'b0, 16'd24464,  1'b1);
        add_case("255",    OP_MUL, "257",   3'b000, 1'b0, 16'd65535,  1'b0);
        add_case("12#3",   OP_ADD, "7",     3'b011, 1'b0, 16'd130,    1'b0);
        add_case("4#6",    OP_SUB, "50",    3'b110, 1'b0, 16'hFFFC,   1'b1);
        add_case("1234",   OP_MUL, "56",    3'b000, 1'b1, 16'd3568,   1'b1);
        add_case("7a8",    OP_MUL, "1e9",   3'b000, 1'b1, 16'd1482,   1'b0);
        add_case("65535",  OP_ADD, "1",     3'b000, 1'b0, 16'd0,      1'b1);
        add_case("65535",  OP_MUL, "65535", 3'b000, 1'b0, 16'd1,      1'b1);
        add_case("0",      OP_SUB, "0",     3'b000, 1'b0, 16'd0,      1'b0);
        table_size = a_q.size();

        wait (nRST === 1'b1);
        @(negedge clk);
        for (int i = 0; i < table_size; i++)
            run_case(a_q[i], op_q[i], b_q[i], bad_op_q[i], noise_q[i], val_q[i], ovf_q[i]);

        for (int i = 0; i < N_RANDOM; i++) begin
            a = "";
            b = "";
            repeat ($urandom_range(1, 5)) a = {a, $sformatf("%0d", $urandom_range(0, 9))};
            repeat ($urandom_range(1, 5)) b = {b, $sformatf("%0d", $urandom_range(0, 9))};
            case ($urandom_range(0, 2))
                0:       code = OP_ADD;
                1:       code = OP_SUB;
                default: code = OP_MUL;
            endcase
            expected = reference_result(operand_value(a), operand_value(b), code);
            run_case(a, code, b, 3'b000, 1'b0, expected[DATA_W-1:0], expected[DATA_W]);
        end

        repeat (2) @(negedge clk);
        u_checker.print_counts();
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: src.f
source/calc_pkg.sv
source/operand_entry.sv
source/calc_controller.sv
source/arith_unit.sv
source/result_display.sv
source/calculator_top.sv
tb/tb_clock_gen.sv
tb/calc_checker.sv
tb/tb_calculator.sv

// File: Bender.yml
package:
  name: calculator

sources:
  - files:
      - source/calc_pkg.sv
      - source/operand_entry.sv
      - source/calc_controller.sv
      - source/arith_unit.sv
      - source/result_display.sv
      - source/calculator_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/calc_checker.sv
      - tb/tb_calculator.sv
